// ==== src/ctr_macros.svh ====
// ##################################################
// register map and window of the CTR accelerator
// and the cipher round count
// ##################################################

`ifndef CTR_MACROS_SVH
`define CTR_MACROS_SVH

// window claimed on the CPU bus, end is exclusive
`define CTR_WIN_BASE  16'hff00
`define CTR_WIN_END   16'hff30

// byte registers
`define CTR_REG_START 16'hff00
`define CTR_REG_STATE 16'hff01
`define CTR_REG_ADDR  16'hff02
`define CTR_REG_LEN   16'hff04
// gap up to the key is unmapped
`define CTR_REG_KEY   16'hff10
`define CTR_REG_CTR   16'hff20

// speck-128/128
`define CTR_ROUNDS    32

`endif

// ==== src/ctr_pkg.sv ====
// ##################################################
// shared types of the CTR accelerator
// ##################################################

`default_nettype none

package ctr_pkg;

    // engine sequence, read back through the state register
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        CRYPT = 2'd2,
        WRITE = 2'd3
    } eng_state_e;

    // one cipher block, byte 0 in bits 7:0
    typedef logic [127:0] block_t;

    // one byte beat towards external memory
    // held until the memory acks it
    typedef struct packed {
        logic        stb;
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== src/byte_reg_bank.sv ====
// ##################################################
// byte addressed CPU register with a typed payload
// ##################################################

`default_nettype none

module byte_reg_bank #(
    parameter type payload_t = logic [15:0]
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [3:0] byte_sel,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output payload_t   value
);

    localparam int NBYTES = $bits(payload_t) / 8;
    localparam int SELW   = $clog2(NBYTES);

    logic [NBYTES-1:0][7:0] bytes_q;
    logic [SELW-1:0]        idx;

    // only the low select bits matter for narrow payloads
    assign idx = byte_sel[SELW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            bytes_q <= '0;
        end else if (we) begin
            bytes_q[idx] <= wdata;
        end
    end

    // read-back is combinational
    assign rdata = bytes_q[idx];

    assign value = payload_t'(bytes_q);

endmodule

`default_nettype wire

// ==== src/speck_core.sv ====
// ##################################################
// iterative speck-128/128 encryptor, one round per
// cycle with the key schedule run alongside
// ##################################################

`default_nettype none

`include "ctr_macros.svh"

module speck_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  ctr_pkg::block_t pt,
    input  ctr_pkg::block_t key,
    output ctr_pkg::block_t ct,
    output logic            done
);

    localparam int RW = $clog2(`CTR_ROUNDS);
    localparam logic [RW-1:0] LAST = RW'(`CTR_ROUNDS - 1);

    logic [63:0]   x_q, y_q, k_q, l_q;
    logic [63:0]   cx, cy, ck, cl;
    logic [63:0]   nx, ny, nk, nl;
    logic [RW-1:0] rnd_q;
    logic [RW-1:0] ri;
    logic          busy_q;

    function automatic logic [63:0] ror8(input logic [63:0] v);
        return {v[7:0], v[63:8]};
    endfunction

    function automatic logic [63:0] rol3(input logic [63:0] v);
        return {v[60:0], v[63:61]};
    endfunction

    // round 0 runs straight off the inputs in the start cycle
    always_comb begin
        cx = start ? pt[127:64]  : x_q;
        cy = start ? pt[63:0]    : y_q;
        cl = start ? key[127:64] : l_q;
        ck = start ? key[63:0]   : k_q;
        ri = start ? '0          : rnd_q;

        nx = (ror8(cx) + cy) ^ ck;
        ny = rol3(cy) ^ nx;
        // key words use the same round with the index as key
        nl = (ror8(cl) + ck) ^ 64'(ri);
        nk = rol3(ck) ^ nl;
    end

    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            x_q <= nx;
            y_q <= ny;
            l_q <= nl;
            k_q <= nk;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            rnd_q  <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                rnd_q  <= RW'(1);
            end else if (busy_q) begin
                rnd_q <= rnd_q + 1'b1;
                if (rnd_q == LAST) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    assign ct = {x_q, y_q};

endmodule

`default_nettype wire

// ==== src/ctr_dma_engine.sv ====
// ##################################################
// CTR block sequencer: reads a block, waits for the
// keystream, writes the XORed block back in place
// ##################################################

`default_nettype none

module ctr_dma_engine (
    input  logic                clk,
    input  logic                rst,
    input  logic                go,
    input  logic [15:0]         base,
    input  logic [15:0]         len,
    input  ctr_pkg::block_t     iv,
    input  ctr_pkg::block_t     keystream,
    input  logic                ks_done,
    output logic                ks_start,
    output ctr_pkg::block_t     ctr_blk,
    output ctr_pkg::eng_state_e state,
    output ctr_pkg::mem_req_t   mem_req,
    input  logic                mem_ack,
    input  logic [7:0]          mem_rdata
);

    ctr_pkg::eng_state_e state_d;

    logic [3:0]      byte_cnt;
    logic [15:0]     blk_off;
    logic [12:0]     blk_rem;
    logic [16:0]     len_up;
    logic [12:0]     nblk;
    logic [12:0]     first_rem;
    logic            beat;
    logic            last_beat;
    logic            start_op;
    ctr_pkg::block_t ctr_q;
    ctr_pkg::block_t rd_buf;
    ctr_pkg::block_t wr_buf;

    // block count rounded up, never below one
    assign len_up    = {1'b0, len} + 17'd15;
    assign nblk      = len_up[16:4];
    assign first_rem = (nblk == 13'd0) ? 13'd0 : nblk - 13'd1;

    assign start_op  = go && (state == ctr_pkg::IDLE);
    assign beat      = mem_req.stb && mem_ack;
    assign last_beat = beat && (byte_cnt == 4'd15);

    always_comb begin
        state_d = state;
        case (state)
            ctr_pkg::IDLE:  if (go) state_d = ctr_pkg::READ;
            ctr_pkg::READ:  if (last_beat) state_d = ctr_pkg::CRYPT;
            ctr_pkg::CRYPT: if (ks_done) state_d = ctr_pkg::WRITE;
            ctr_pkg::WRITE: begin
                if (last_beat) begin
                    state_d = (blk_rem != 13'd0) ? ctr_pkg::READ : ctr_pkg::IDLE;
                end
            end
            default: state_d = ctr_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ctr_pkg::IDLE;
            byte_cnt <= 4'd0;
            blk_off  <= 16'd0;
            blk_rem  <= 13'd0;
            ks_start <= 1'b0;
        end else begin
            state <= state_d;
            // core kicks off in the first CRYPT cycle
            ks_start <= last_beat && (state == ctr_pkg::READ);
            if (start_op) begin
                byte_cnt <= 4'd0;
                blk_off  <= 16'd0;
                blk_rem  <= first_rem;
            end else begin
                if (beat) begin
                    byte_cnt <= byte_cnt + 4'd1;
                end
                if (last_beat && state == ctr_pkg::WRITE && blk_rem != 13'd0) begin
                    blk_off <= blk_off + 16'd16;
                    blk_rem <= blk_rem - 13'd1;
                end
            end
        end
    end

    // running counter, one step per finished block
    always_ff @(posedge clk) begin
        if (start_op) begin
            ctr_q <= iv;
        end else if (last_beat && state == ctr_pkg::WRITE) begin
            ctr_q <= ctr_q + 128'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat && state == ctr_pkg::READ) begin
            rd_buf[{byte_cnt, 3'b000} +: 8] <= mem_rdata;
        end
        if (ks_done && state == ctr_pkg::CRYPT) begin
            wr_buf <= rd_buf ^ keystream;
        end
    end

    assign ctr_blk = ctr_q;

    // address wraps modulo 64k
    always_comb begin
        mem_req.stb   = (state == ctr_pkg::READ) || (state == ctr_pkg::WRITE);
        mem_req.wr    = (state == ctr_pkg::WRITE);
        mem_req.addr  = base + blk_off + {12'd0, byte_cnt};
        mem_req.wdata = wr_buf[{byte_cnt, 3'b000} +: 8];
    end

endmodule

`default_nettype wire

// ==== src/ctr_accel_top.sv ====
// ##################################################
// CTR accelerator top: CPU register window, engine
// and speck core
// ##################################################

`default_nettype none

`include "ctr_macros.svh"

module ctr_accel_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              stb,
    input  logic              wr,
    input  logic [15:0]       addr,
    input  logic [7:0]        wdata,
    output logic              ack,
    output logic [7:0]        rdata,
    output ctr_pkg::mem_req_t mem_req,
    input  logic              mem_ack,
    input  logic [7:0]        mem_rdata
);

    ctr_pkg::eng_state_e eng_state;
    ctr_pkg::block_t     key_val, iv_val, ctr_blk, keystream;

    logic [15:0] base_val, len_val;
    logic [7:0]  addr_rd, len_rd, key_rd, ctr_rd;
    logic        sel_start, sel_state, sel_addr, sel_len, sel_key, sel_ctr;
    logic        win_hit, wr_en, go, ks_start, ks_done;

    assign win_hit = (addr >= `CTR_WIN_BASE) && (addr < `CTR_WIN_END);
    assign ack     = stb && win_hit;

    assign sel_start = (addr == `CTR_REG_START);
    assign sel_state = (addr == `CTR_REG_STATE);
    assign sel_addr  = ({addr[15:1], 1'b0} == `CTR_REG_ADDR);
    assign sel_len   = ({addr[15:1], 1'b0} == `CTR_REG_LEN);
    assign sel_key   = ({addr[15:4], 4'h0} == `CTR_REG_KEY);
    assign sel_ctr   = ({addr[15:4], 4'h0} == `CTR_REG_CTR);

    // registers are frozen while the engine runs
    assign wr_en = ack && wr && (eng_state == ctr_pkg::IDLE);
    assign go    = wr_en && sel_start && wdata[0];

    byte_reg_bank #(.payload_t(logic [15:0])) u_addr (
        .clk(clk), .rst(rst), .we(wr_en && sel_addr), .byte_sel(addr[3:0]),
        .wdata(wdata), .rdata(addr_rd), .value(base_val)
    );
    byte_reg_bank #(.payload_t(logic [15:0])) u_len (
        .clk(clk), .rst(rst), .we(wr_en && sel_len), .byte_sel(addr[3:0]),
        .wdata(wdata), .rdata(len_rd), .value(len_val)
    );
    byte_reg_bank #(.payload_t(ctr_pkg::block_t)) u_key (
        .clk(clk), .rst(rst), .we(wr_en && sel_key), .byte_sel(addr[3:0]),
        .wdata(wdata), .rdata(key_rd), .value(key_val)
    );
    byte_reg_bank #(.payload_t(ctr_pkg::block_t)) u_ctr (
        .clk(clk), .rst(rst), .we(wr_en && sel_ctr), .byte_sel(addr[3:0]),
        .wdata(wdata), .rdata(ctr_rd), .value(iv_val)
    );

    // start register and holes read as zero
    always_comb begin
        if (sel_state)     rdata = {6'd0, eng_state};
        else if (sel_addr) rdata = addr_rd;
        else if (sel_len)  rdata = len_rd;
        else if (sel_key)  rdata = key_rd;
        else if (sel_ctr)  rdata = ctr_rd;
        else               rdata = 8'd0;
    end

    ctr_dma_engine u_eng (
        .clk(clk), .rst(rst), .go(go), .base(base_val), .len(len_val),
        .iv(iv_val), .keystream(keystream), .ks_done(ks_done),
        .ks_start(ks_start), .ctr_blk(ctr_blk), .state(eng_state),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    speck_core u_cipher (
        .clk(clk), .rst(rst), .start(ks_start), .pt(ctr_blk), .key(key_val),
        .ct(keystream), .done(ks_done)
    );

endmodule

`default_nettype wire

// ==== verif/ctr_accel_props.sv ====
// ##################################################
// handshake properties of the CTR accelerator
// ##################################################

`default_nettype none

`include "ctr_macros.svh"

module ctr_accel_props (
    input logic                clk,
    input logic                rst,
    input logic                stb,
    input logic                wr,
    input logic [15:0]         addr,
    input logic [7:0]          wdata,
    input logic                ack,
    input ctr_pkg::mem_req_t   mem_req,
    input logic                mem_ack,
    input logic                ks_start,
    input logic                ks_done,
    input ctr_pkg::eng_state_e eng_state
);

    // engine leaves IDLE exactly on an accepted start write
    a_cpu_start: assert property (@(posedge clk) disable iff (rst)
        (eng_state == ctr_pkg::IDLE) |=>
            ((eng_state == ctr_pkg::READ) ==
             $past(stb && wr && ack && addr == `CTR_REG_START && wdata[0])))
        else $error("engine start does not follow the start register write");

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_req.stb && !mem_ack) |=> $stable(mem_req))
        else $error("memory request changed before its ack");

    // write phase opens right after done, 33 cycles after the core start
    a_wr_after_ks: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req.wr) |-> ($past(ks_done) && $past(ks_start, 33)))
        else $error("memory write started before the keystream was ready");

endmodule

bind ctr_accel_top ctr_accel_props u_props (
    .clk(clk), .rst(rst), .stb(stb), .wr(wr), .addr(addr), .wdata(wdata), .ack(ack),
    .mem_req(mem_req), .mem_ack(mem_ack), .ks_start(ks_start), .ks_done(ks_done),
    .eng_state(eng_state)
);

`default_nettype wire

// ==== verif/ctr_accel_tb.sv ====
// ##################################################
// testbench for the CTR accelerator with a memory
// model and a speck/CTR reference model
// ##################################################

`default_nettype none

`include "ctr_macros.svh"

module ctr_accel_tb;

    localparam int NUM_ENTRIES = 4;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 2000;

    typedef struct packed {
        logic [15:0]     base;
        logic [15:0]     len;
        ctr_pkg::block_t key;
        ctr_pkg::block_t iv;
        logic            probe;
    } entry_t;

    logic              clk = 1'b0;
    logic              rst, stb, wr, ack, mem_ack;
    logic [15:0]       addr;
    logic [7:0]        wdata, rdata, mem_rdata;
    ctr_pkg::mem_req_t mem_req;
    logic [7:0]        mem [0:65535];
    logic [7:0]        mem_exp [0:65535];
    integer            seed = 32'h1686;
    int                errors = 0;
    int                mem_errors = 0;
    entry_t            tests [NUM_ENTRIES];

    ctr_accel_top dut0 (.*);

    always #5 clk = ~clk;

    // byte memory with 0 to 3 wait cycles before each ack
    initial begin
        logic [1:0] wait_cnt;
        mem_ack   <= 1'b0;
        mem_rdata <= 8'h00;
        wait_cnt  = 2'd0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'($random(seed));
        end
        forever begin
            @(posedge clk);
            if (mem_ack) begin
                // beat completes at this edge
                if (mem_req.wr) begin
                    mem[mem_req.addr] = mem_req.wdata;
                end
                mem_ack  <= 1'b0;
                wait_cnt = 2'($random(seed));
            end else if (mem_req.stb) begin
                if (wait_cnt == 2'd0) begin
                    mem_ack   <= 1'b1;
                    mem_rdata <= mem[mem_req.addr];
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
        end
    end

    // cycle budget scales with the table length
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    // speck-128/128 with x and l0 in the upper halves
    function automatic ctr_pkg::block_t speck_encrypt(input ctr_pkg::block_t pt,
                                                       input ctr_pkg::block_t key);
        logic [63:0] x, y, l, k;
        x = pt[127:64];
        y = pt[63:0];
        l = key[127:64];
        k = key[63:0];
        for (int i = 0; i < `CTR_ROUNDS; i++) begin
            x = ({x[7:0], x[63:8]} + y) ^ k;
            y = {y[60:0], y[63:61]} ^ x;
            l = ({l[7:0], l[63:8]} + k) ^ 64'(i);
            k = {k[60:0], k[63:61]} ^ l;
        end
        return {x, y};
    endfunction

    // expected contents of the 48 byte window with byte 0 at ff00
    function automatic logic [383:0] window_image(input entry_t t);
        return {t.iv, t.key, 80'h0, t.len, t.base, 16'h0};
    endfunction

    // one CPU beat driven on the rising edge and sampled mid-cycle
    task automatic bus_access(input logic w, input logic [15:0] a, input logic [7:0] d,
                              input logic exp_ack, output logic [7:0] got);
        @(posedge clk);
        stb   <= 1'b1;
        wr    <= w;
        addr  <= a;
        wdata <= d;
        @(negedge clk);
        got = rdata;
        if (ack !== exp_ack) begin
            errors++;
            $display("** Error at %0t: ack got %b expected %b (addr %h)", $time, ack, exp_ack, a);
        end
        @(posedge clk);
        stb <= 1'b0;
        wr  <= 1'b0;
    endtask

    task automatic check_regs(input entry_t t);
        logic [383:0] img;
        logic [7:0]   got;
        img = window_image(t);
        for (int off = 0; off < 48; off++) begin
            bus_access(1'b0, 16'(`CTR_WIN_BASE + off), 8'h00, 1'b1, got);
            if (got !== img[8*off +: 8]) begin
                errors++;
                $display("** Error at %0t: rdata at %h got %h expected %h", $time,
                         16'(`CTR_WIN_BASE + off), got, img[8*off +: 8]);
            end
        end
    endtask

    // program and run one entry and then check registers and all of memory
    task automatic run_entry(input entry_t t);
        logic [383:0]    img;
        logic [7:0]      got;
        logic [15:0]     a;
        ctr_pkg::block_t ks;
        int              nblk;
        img = window_image(t);
        for (int off = 2; off < 48; off++) begin
            if (off < 6 || off >= 16) begin
                bus_access(1'b1, 16'(`CTR_WIN_BASE + off), img[8*off +: 8], 1'b1, got);
            end
        end
        check_regs(t);
        // ceil(len/16) blocks and never fewer than one
        nblk = (t.len == 16'd0) ? 1 : (int'(t.len) + 15) / 16;
        for (int b = 0; b < nblk; b++) begin
            ks = speck_encrypt(t.iv + 128'(b), t.key);
            for (int j = 0; j < 16; j++) begin
                a = 16'(int'(t.base) + 16 * b + j);
                mem_exp[a] = mem_exp[a] ^ ks[8*j +: 8];
            end
        end
        bus_access(1'b1, `CTR_REG_START, 8'h01, 1'b1, got);
        if (t.probe) begin
            // engine is busy so both writes are dropped
            bus_access(1'b1, `CTR_REG_KEY, ~t.key[7:0], 1'b1, got);
            bus_access(1'b1, 16'(`CTR_REG_CTR + 5), ~t.iv[47:40], 1'b1, got);
        end
        got = 8'hff;
        while (got !== 8'h00) begin
            bus_access(1'b0, `CTR_REG_STATE, 8'h00, 1'b1, got);
        end
        check_regs(t);
        for (int i = 0; i < 65536; i++) begin
            if (mem[i] !== mem_exp[i]) begin
                if (mem_errors < 8) begin
                    $display("** Error at %0t: mem[%h] got %h expected %h",
                             $time, 16'(i), mem[i], mem_exp[i]);
                end
                mem_errors++;
            end
        end
    endtask

    initial begin
        logic [7:0] got;
        rst   <= 1'b1;
        stb   <= 1'b0;
        wr    <= 1'b0;
        addr  <= 16'h0000;
        wdata <= 8'h00;
        // entry 0 carries the published speck-128/128 vector
        tests[0] = {16'h1000, 16'd16, 128'h0f0e0d0c0b0a0908_0706050403020100,
                    128'h6c61766975716520_7469206564616d20, 1'b0};
        tests[1] = {16'h2345, 16'd50, 128'h1b2c3d4e5f607182_93a4b5c6d7e8f90a,
                    128'h0123456789abcdef_fffffffffffffffe, 1'b0};
        tests[2] = {16'h4000, 16'd33, 128'hdeadbeef01234567_89abcdef76543210,
                    128'h55aa55aa12345678_9abcdef000000007, 1'b1};
        tests[3] = {16'hfff8, 16'd0, 128'hc001d00d0badf00d_1122334455667788,
                    128'hffffffffffffffff_ffffffffffffffff, 1'b0};
        if (speck_encrypt(tests[0].iv, tests[0].key) !==
            128'ha65d985179783265_7860fedf5c570d18) begin
            errors++;
            $display("reference speck model does not reproduce its known-answer vector");
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 65536; i++) begin
            mem_exp[i] = mem[i];
        end
        @(negedge clk);
        if (mem_req.stb !== 1'b0) begin
            errors++;
            $display("** Error at %0t: mem_req.stb got %b expected 0", $time, mem_req.stb);
        end
        check_regs('0);
        // just outside the window on both sides
        bus_access(1'b0, 16'hfeff, 8'h00, 1'b0, got);
        bus_access(1'b1, `CTR_WIN_END, 8'h5a, 1'b0, got);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(tests[e]);
        end
        $display("register errors %0d, memory errors %0d", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/ctr_pkg.sv
src/byte_reg_bank.sv
src/speck_core.sv
src/ctr_dma_engine.sv
src/ctr_accel_top.sv
verif/ctr_accel_props.sv
verif/ctr_accel_tb.sv

// ==== Makefile ====
# Verilator flow for the CTR accelerator

VERILATOR  ?= verilator
TOP        ?= ctr_accel_tb
RTL_TOP    ?= ctr_accel_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
